// File: Bender.yml
package:
  name: rv32i_wb_core

sources:
  - source/core_pkg.sv
  - source/core_decoder.sv
  - source/core_regfile.sv
  - source/core_exec_unit.sv
  - source/core_ctrl.sv
  - source/core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/core_tb.sv

// File: dv/core_tb_iss.svh
`ifndef CORE_TB_ISS_SVH
`define CORE_TB_ISS_SVH

// reference state, loaded by gen_program and advanced by run_model
word_t ref_mem  [MEM_WORDS];
word_t ref_regs [NUM_REGS];
word_t fetch_trace  [$];
word_t store_addr_q [$];
word_t store_data_q [$];

function automatic reg_addr_t rand_reg();
    if ($urandom_range(0, 7) == 0) begin
        return 5'd3;  // bias toward gp
    end
    return reg_addr_t'($urandom_range(0, NUM_REGS - 1));
endfunction

// forward slot, the slot after the last instruction is the exit address
function automatic int unsigned fwd_slot(input int unsigned slot);
    int unsigned tgt;
    tgt = slot + $urandom_range(1, 8);
    return (tgt > NUM_INSTR) ? NUM_INSTR : tgt;
endfunction

function automatic logic [11:0] data_off();
    return 12'(DATA_BASE + 4 * $urandom_range(0, 255));
endfunction

task automatic gen_program();
    int unsigned i;
    int unsigned sel;
    int unsigned r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    reg_addr_t   rd;
    for (int a = 0; a < MEM_WORDS; a++) begin
        // lower half tagged with its address, data half random
        ref_mem[a] = (a < MEM_WORDS / 2) ? (32'h0BAD_0000 | (word_t'(a) << 2)) : $urandom();
    end
    i = 0;
    while (i < NUM_INSTR) begin
        sel = $urandom_range(0, 99);
        rd  = rand_reg();
        f3  = 3'($urandom_range(0, 7));
        f7  = F7_BASE;
        if (sel < 28) begin
            if ((f3 == F3_ADD_SUB || f3 == F3_SR) && $urandom_range(0, 1) == 1) begin
                f7 = F7_ALT;
            end
            ref_mem[i] = {f7, rand_reg(), rand_reg(), f3, rd, OPC_OP};
        end else if (sel < 48) begin
            if (f3 == F3_SR && $urandom_range(0, 1) == 1) begin
                f7 = F7_ALT;
            end
            if (f3 == F3_SLL || f3 == F3_SR) begin
                ref_mem[i] = {f7, 5'($urandom_range(0, 31)), rand_reg(), f3, rd, OPC_OP_IMM};
            end else begin
                ref_mem[i] = {12'($urandom()), rand_reg(), f3, rd, OPC_OP_IMM};
            end
        end else if (sel < 53) begin
            ref_mem[i] = {20'($urandom()), rd, OPC_LUI};
        end else if (sel < 57) begin
            ref_mem[i] = {20'($urandom()), rd, OPC_AUIPC};
        end else if (sel < 67) begin
            r    = $urandom_range(0, 5);
            f3   = 3'((r < 2) ? r : r + 2);  // beq bne blt bge bltu bgeu
            boff = 13'((fwd_slot(i) - i) * 4);
            ref_mem[i] = {boff[12], boff[10:5], rand_reg(), rand_reg(), f3,
                          boff[4:1], boff[11], OPC_BRANCH};
        end else if (sel < 70) begin
            joff = 21'((fwd_slot(i) - i) * 4);
            ref_mem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
        end else if (sel < 73) begin
            ref_mem[i] = {12'(fwd_slot(i) * 4), 5'd0, F3_JALR, rd, OPC_JALR};
        end else if (sel < 84) begin
            imm = data_off();
            ref_mem[i] = {imm, 5'd0, F3_LW, rd, OPC_LOAD};
            if (i + 1 < NUM_INSTR) begin
                i++;
                imm = data_off();  // store the loaded word right back out
                ref_mem[i] = {imm[11:5], rd, 5'd0, F3_SW, imm[4:0], OPC_STORE};
            end
        end else if (sel < 97) begin
            imm = data_off();
            ref_mem[i] = {imm[11:5], rand_reg(), 5'd0, F3_SW, imm[4:0], OPC_STORE};
        end else begin
            ref_mem[i] = {25'($urandom()), 7'b0001011};  // custom-0, executes as a no-op
        end
        i++;
    end
endtask

function automatic word_t model_alu(input logic [2:0] f3, input logic alt, input logic is_reg,
                                    input word_t a, input word_t b);
    case (f3)
        F3_ADD_SUB: return (is_reg && alt) ? a - b : a + b;
        F3_SLL:     return a << b[4:0];
        F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
        F3_XOR:     return a ^ b;
        F3_SR:      return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        F3_OR:      return a | b;
        default:    return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic write_reg(input reg_addr_t rd, input word_t value);
    if (rd != 5'd0) begin
        ref_regs[rd] = value;
    end
endtask

task automatic run_model();
    word_t      pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      nxt;
    word_t      addr;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    reg_addr_t  rd;
    logic [2:0] f3;
    int         steps;
    foreach (ref_regs[k]) begin
        ref_regs[k] = '0;
    end
    pc    = RESET_PC;
    steps = 0;
    while (pc != EXIT_PC && steps < 4 * NUM_INSTR) begin
        fetch_trace.push_back(pc);
        ins   = ref_mem[pc[10:2]];
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        case (ins[6:0])
            OPC_OP:     write_reg(rd, model_alu(f3, ins[30], 1'b1, a, b));
            OPC_OP_IMM: write_reg(rd, model_alu(f3, ins[30], 1'b0, a, imm_i));
            OPC_LUI:    write_reg(rd, {ins[31:12], 12'h000});
            OPC_AUIPC:  write_reg(rd, pc + {ins[31:12], 12'h000});
            OPC_JAL: begin
                write_reg(rd, pc + 32'd4);
                nxt = pc + imm_j;
            end
            OPC_JALR: begin
                nxt = (a + imm_i) & ~32'd1;
                write_reg(rd, pc + 32'd4);
            end
            OPC_BRANCH: begin
                if (branch_taken(f3, a, b)) begin
                    nxt = pc + imm_b;
                end
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                write_reg(rd, ref_mem[addr[10:2]]);
            end
            OPC_STORE: begin
                addr = (a + imm_s) & ~32'd3;
                store_addr_q.push_back(addr);
                store_data_q.push_back(b);
                ref_mem[addr[10:2]] = b;
            end
            default: ;
        endcase
        pc = nxt;
        steps++;
    end
endtask

`endif

// File: dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_INSTR    = 200;
    localparam int          MEM_WORDS    = 512;
    localparam int          NUM_REGS     = 32;
    localparam word_t       RESET_PC     = 32'h0000_0000;
    localparam word_t       EXIT_PC      = 32'h0000_0320;
    localparam word_t       DATA_BASE    = 32'h0000_0400;
    localparam int unsigned SEED         = 32'h8675;
    // instructions x bus phases x cycles per phase x period x margin
    localparam int          WATCHDOG_NS  = NUM_INSTR * 2 * 5 * CLK_PERIOD * 2
                                           + RESET_CYCLES * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  cyc;
    logic  stb;
    logic  we;
    logic  ack;
    logic  exit_hit;
    word_t adr;
    word_t wdata;
    word_t rdata;
    word_t gp;

    word_t       mem [MEM_WORDS];
    int unsigned wait_tab [1024];
    int unsigned fetch_idx;
    int unsigned store_idx;
    int          checks;
    int          errors;

    `include "core_tb_iss.svh"

    core_top #(
        .RESET_PC (RESET_PC),
        .EXIT_PC  (EXIT_PC),
        .NUM_REGS (NUM_REGS)
    ) dut (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .cyc_o   (cyc),
        .stb_o   (stb),
        .we_o    (we),
        .adr_o   (adr),
        .dat_o   (wdata),
        .dat_i   (rdata),
        .ack_i   (ack),
        .exit_o  (exit_hit),
        .gp_o    (gp)
    );

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] t=%0t %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] t=%0t %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at t=%0t: %s", $time, what);
        end
    endtask

    // serves one acknowledged bus cycle against the model traces
    task automatic serve_request();
        word_t addr;
        addr = adr;
        check_true(addr < 32'h800, "bus access outside the memory");
        if (we) begin
            if (store_idx < store_addr_q.size()) begin
                compare_word("adr_o", store_addr_q[store_idx], addr);
                compare_word("dat_o", store_data_q[store_idx], wdata);
            end else begin
                check_true(1'b0, "core stored more words than the model");
            end
            store_idx++;
            mem[addr[10:2]] = wdata;
        end else begin
            if (addr < DATA_BASE) begin
                if (fetch_idx < fetch_trace.size()) begin
                    compare_word("adr_o", fetch_trace[fetch_idx], addr);
                end else begin
                    check_true(1'b0, "core fetched past the end of the model trace");
                end
                fetch_idx++;
            end
            rdata = mem[addr[10:2]];
        end
        ack = 1'b1;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : wb_slave
        int unsigned req_count;
        req_count = 0;
        ack       = 1'b0;
        rdata     = '0;
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            ack = 1'b0;
            check_true(stb === cyc, "stb_o does not follow cyc_o");
            if (rst_n && cyc && stb) begin
                repeat (wait_tab[req_count % 1024]) begin
                    @(posedge clk);
                    #(DRIVE_DELAY);
                end
                req_count++;
                serve_request();
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at t=%0t before the core reached its exit address", $time);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int n;
        rst_n     = 1'b0;
        checks    = 0;
        errors    = 0;
        fetch_idx = 0;
        store_idx = 0;
        void'($urandom(SEED));
        gen_program();
        foreach (wait_tab[k]) begin
            wait_tab[k] = $urandom_range(0, 3);
        end
        mem = ref_mem;
        run_model();
        $display("model: %0d fetches, %0d stores, x3 = %h",
                 fetch_trace.size(), store_addr_q.size(), ref_regs[3]);

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            compare_bit("cyc_o", 1'b0, cyc);
            compare_bit("stb_o", 1'b0, stb);
            compare_bit("exit_o", 1'b0, exit_hit);
        end
        rst_n = 1'b1;
        for (n = 0; n < 8 && cyc !== 1'b1; n++) begin
            compare_bit("exit_o", 1'b0, exit_hit);
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        check_true(cyc === 1'b1, "no bus request appeared after reset");
        compare_word("adr_o", RESET_PC, adr);
        compare_bit("we_o", 1'b0, we);

        while (exit_hit !== 1'b1) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        repeat (20) begin  // halted core stays off the bus
            @(posedge clk);
            #(DRIVE_DELAY);
            compare_bit("cyc_o", 1'b0, cyc);
            compare_bit("stb_o", 1'b0, stb);
            compare_bit("exit_o", 1'b1, exit_hit);
        end
        compare_word("gp_o", ref_regs[3], gp);
        compare_word("store count", store_addr_q.size(), store_idx);
        compare_word("fetch count", fetch_trace.size(), fetch_idx);

        $display("checks %0d, errors %0d, fetches %0d, stores %0d",
                 checks, errors, fetch_idx, store_idx);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: source/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000,
    parameter core_pkg::word_t EXIT_PC  = 32'h0000_0320
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    output logic               cyc_o,
    output logic               stb_o,
    output logic               we_o,
    output core_pkg::word_t    adr_o,
    output core_pkg::word_t    dat_o,
    input  core_pkg::word_t    dat_i,
    input  logic               ack_i,
    output core_pkg::word_t    instr_o,
    output core_pkg::word_t    pc_o,
    input  core_pkg::wb_sel_e  wb_sel_i,
    input  logic               is_load_i,
    input  logic               is_store_i,
    input  logic               is_jump_i,
    input  logic               is_branch_i,
    input  core_pkg::word_t    imm_i,
    input  core_pkg::word_t    result_i,
    input  logic               br_taken_i,
    input  core_pkg::word_t    store_data_i,
    output logic               rd_wen_o,
    output core_pkg::word_t    rd_data_o,
    output logic               exit_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_MEM, S_HALT} state_e;

    state_e state_q;
    word_t  pc_q;
    word_t  instr_q;
    logic   cyc_q;
    logic   we_q;
    word_t  adr_q;
    word_t  dat_q;
    word_t  pc_plus4;
    word_t  next_pc;
    logic   mem_op;

    assign pc_plus4 = pc_q + 32'd4;
    assign mem_op   = is_load_i || is_store_i;

    always_comb begin
        if (is_branch_i && br_taken_i) begin
            next_pc = pc_q + imm_i;
        end else if (is_jump_i) begin
            next_pc = result_i;  // jal and jalr targets come from the alu
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_FETCH;
            pc_q    <= RESET_PC;
            cyc_q   <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (!cyc_q) begin
                        if (pc_q == EXIT_PC) begin
                            state_q <= S_HALT;
                        end else begin
                            cyc_q <= 1'b1;
                            we_q  <= 1'b0;
                        end
                    end else if (ack_i) begin
                        cyc_q   <= 1'b0;
                        state_q <= S_EXECUTE;
                    end
                end
                S_EXECUTE: begin
                    if (mem_op) begin
                        cyc_q   <= 1'b1;
                        we_q    <= is_store_i;
                        state_q <= S_MEM;
                    end else begin
                        pc_q <= next_pc;
                        if (next_pc == EXIT_PC) begin
                            state_q <= S_HALT;
                        end else begin
                            cyc_q   <= 1'b1;  // next fetch right away
                            state_q <= S_FETCH;
                        end
                    end
                end
                S_MEM: begin
                    if (ack_i) begin
                        cyc_q   <= 1'b0;
                        we_q    <= 1'b0;
                        pc_q    <= pc_plus4;
                        state_q <= (pc_plus4 == EXIT_PC) ? S_HALT : S_FETCH;
                    end
                end
                default: ;  // halted for good
            endcase
        end
    end

    // bus payload and instruction register
    always_ff @(posedge clk_i) begin
        if (state_q == S_FETCH && !cyc_q) begin
            adr_q <= {pc_q[XLEN-1:2], 2'b00};
        end
        if (state_q == S_FETCH && cyc_q && ack_i) begin
            instr_q <= dat_i;
        end
        if (state_q == S_EXECUTE) begin
            adr_q <= mem_op ? {result_i[XLEN-1:2], 2'b00} : {next_pc[XLEN-1:2], 2'b00};
            dat_q <= store_data_i;
        end
    end

    always_comb begin
        case (wb_sel_i)
            WB_PC4:  rd_data_o = pc_plus4;
            WB_MEM:  rd_data_o = dat_i;
            default: rd_data_o = result_i;
        endcase
    end

    assign rd_wen_o = (state_q == S_EXECUTE && (wb_sel_i == WB_ALU || wb_sel_i == WB_PC4)) ||
                      (state_q == S_MEM && ack_i && wb_sel_i == WB_MEM);

    assign cyc_o   = cyc_q;
    assign stb_o   = cyc_q;
    assign we_o    = we_q;
    assign adr_o   = adr_q;
    assign dat_o   = dat_q;
    assign instr_o = instr_q;
    assign pc_o    = pc_q;
    assign exit_o  = (pc_q == EXIT_PC);

endmodule

// File: source/core_decoder.sv
`timescale 1ns/1ps

module core_decoder #(
    parameter int NUM_REGS = 32
) (
    input  core_pkg::word_t     instr_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output core_pkg::reg_addr_t rd_addr_o,
    output core_pkg::word_t     imm_o,
    output core_pkg::alu_op_e   alu_op_o,
    output core_pkg::op1_sel_e  op1_sel_o,
    output core_pkg::op2_sel_e  op2_sel_o,
    output core_pkg::wb_sel_e   wb_sel_o,
    output logic                is_load_o,
    output logic                is_store_o,
    output logic                is_jump_o,
    output logic                is_branch_o
);
    import core_pkg::*;

    localparam reg_addr_t REG_MASK = reg_addr_t'(NUM_REGS - 1);  // rv32e keeps 4 bits

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       funct7_ok;
    logic       is_shift;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    alu_op_e    arith_op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign alt    = instr_i[30];

    assign rs1_addr_o = instr_i[19:15] & REG_MASK;
    assign rs2_addr_o = instr_i[24:20] & REG_MASK;
    assign rd_addr_o  = instr_i[11:7] & REG_MASK;

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'h000};

    // alt funct7 only legal on sub and sra/srai
    assign funct7_ok = (funct7 == F7_BASE) ||
                       (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
    assign is_shift  = (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // defaults decode as a no-op
        imm_o       = imm_i;
        alu_op_o    = ALU_ADD;
        op1_sel_o   = OP1_RS1;
        op2_sel_o   = OP2_IMM;
        wb_sel_o    = WB_NONE;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_jump_o   = 1'b0;
        is_branch_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7_ok) begin
                    alu_op_o  = arith_op;
                    op2_sel_o = OP2_RS2;
                    wb_sel_o  = WB_ALU;
                end
            end
            OPC_OP_IMM: begin
                if (funct7_ok || !is_shift) begin
                    alu_op_o = arith_op;
                    wb_sel_o = WB_ALU;
                end
            end
            OPC_LUI: begin
                imm_o     = imm_u;
                op1_sel_o = OP1_ZERO;
                alu_op_o  = ALU_COPY2;
                wb_sel_o  = WB_ALU;
            end
            OPC_AUIPC: begin
                imm_o     = imm_u;
                op1_sel_o = OP1_PC;
                wb_sel_o  = WB_ALU;
            end
            OPC_JAL: begin
                imm_o     = imm_j;
                op1_sel_o = OP1_PC;
                wb_sel_o  = WB_PC4;
                is_jump_o = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    alu_op_o  = ALU_JALR;
                    wb_sel_o  = WB_PC4;
                    is_jump_o = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm_o       = imm_b;
                op2_sel_o   = OP2_RS2;
                is_branch_o = 1'b1;
                case (funct3)
                    F3_BEQ:  alu_op_o = BR_BEQ;
                    F3_BNE:  alu_op_o = BR_BNE;
                    F3_BLT:  alu_op_o = BR_BLT;
                    F3_BGE:  alu_op_o = BR_BGE;
                    F3_BLTU: alu_op_o = BR_BLTU;
                    F3_BGEU: alu_op_o = BR_BGEU;
                    default: is_branch_o = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW) begin
                    wb_sel_o  = WB_MEM;
                    is_load_o = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    imm_o      = imm_s;
                    is_store_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: source/core_exec_unit.sv
`timescale 1ns/1ps

module core_exec_unit (
    input  core_pkg::alu_op_e  alu_op_i,
    input  core_pkg::op1_sel_e op1_sel_i,
    input  core_pkg::op2_sel_e op2_sel_i,
    input  core_pkg::word_t    rs1_data_i,
    input  core_pkg::word_t    rs2_data_i,
    input  core_pkg::word_t    pc_i,
    input  core_pkg::word_t    imm_i,
    output core_pkg::word_t    result_o,
    output logic               br_taken_o
);
    import core_pkg::*;

    word_t op1;
    word_t op2;
    word_t sum;
    logic  eq;
    logic  lt;
    logic  ltu;

    always_comb begin
        case (op1_sel_i)
            OP1_RS1: op1 = rs1_data_i;
            OP1_PC:  op1 = pc_i;
            default: op1 = '0;
        endcase
    end

    assign op2 = (op2_sel_i == OP2_IMM) ? imm_i : rs2_data_i;
    assign sum = op1 + op2;
    assign eq  = (op1 == op2);
    assign lt  = ($signed(op1) < $signed(op2));
    assign ltu = (op1 < op2);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   result_o = sum;
            ALU_SUB:   result_o = op1 - op2;
            ALU_AND:   result_o = op1 & op2;
            ALU_OR:    result_o = op1 | op2;
            ALU_XOR:   result_o = op1 ^ op2;
            ALU_SLL:   result_o = op1 << op2[4:0];
            ALU_SRL:   result_o = op1 >> op2[4:0];
            ALU_SRA:   result_o = word_t'($signed(op1) >>> op2[4:0]);
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, ltu};
            ALU_JALR:  result_o = {sum[XLEN-1:1], 1'b0};
            ALU_COPY2: result_o = op2;
            default:   result_o = '0;  // branches only compare
        endcase
    end

    always_comb begin
        case (alu_op_i)
            BR_BEQ:  br_taken_o = eq;
            BR_BNE:  br_taken_o = !eq;
            BR_BLT:  br_taken_o = lt;
            BR_BGE:  br_taken_o = !lt;
            BR_BLTU: br_taken_o = ltu;
            BR_BGEU: br_taken_o = !ltu;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

// File: source/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR,   // add, then clear bit 0
        ALU_COPY2,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic       {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // sub, sra

endpackage

// File: source/core_regfile.sv
`timescale 1ns/1ps

module core_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  logic                rd_wen_i,
    input  core_pkg::word_t     rd_data_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    output core_pkg::word_t     gp_o
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    assign gp_o       = regs[3];

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000,
    parameter core_pkg::word_t EXIT_PC  = 32'h0000_0320,
    parameter int              NUM_REGS = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    output logic            cyc_o,
    output logic            stb_o,
    output logic            we_o,
    output core_pkg::word_t adr_o,
    output core_pkg::word_t dat_o,
    input  core_pkg::word_t dat_i,
    input  logic            ack_i,
    output logic            exit_o,
    output core_pkg::word_t gp_o
);
    import core_pkg::*;

    word_t     instr;
    word_t     pc;
    word_t     imm;
    word_t     result;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    logic      is_load;
    logic      is_store;
    logic      is_jump;
    logic      is_branch;
    logic      br_taken;
    logic      rd_wen;

    core_ctrl #(
        .RESET_PC (RESET_PC),
        .EXIT_PC  (EXIT_PC)
    ) u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cyc_o        (cyc_o),
        .stb_o        (stb_o),
        .we_o         (we_o),
        .adr_o        (adr_o),
        .dat_o        (dat_o),
        .dat_i        (dat_i),
        .ack_i        (ack_i),
        .instr_o      (instr),
        .pc_o         (pc),
        .wb_sel_i     (wb_sel),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .is_jump_i    (is_jump),
        .is_branch_i  (is_branch),
        .imm_i        (imm),
        .result_i     (result),
        .br_taken_i   (br_taken),
        .store_data_i (rs2_data),
        .rd_wen_o     (rd_wen),
        .rd_data_o    (rd_data),
        .exit_o       (exit_o)
    );

    core_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .instr_i     (instr),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .op1_sel_o   (op1_sel),
        .op2_sel_o   (op2_sel),
        .wb_sel_o    (wb_sel),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_jump_o   (is_jump),
        .is_branch_o (is_branch)
    );

    core_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_wen_i   (rd_wen),
        .rd_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    core_exec_unit u_exec (
        .alu_op_i   (alu_op),
        .op1_sel_i  (op1_sel),
        .op2_sel_i  (op2_sel),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .imm_i      (imm),
        .result_o   (result),
        .br_taken_o (br_taken)
    );

endmodule

// File: tb.f
+incdir+dv
source/core_pkg.sv
source/core_decoder.sv
source/core_regfile.sv
source/core_exec_unit.sv
source/core_ctrl.sv
source/core_top.sv
dv/core_tb.sv
